//--- hdl/tcb_pkg.sv
/*
  shared widths and enums for the shared memory subsystem
  imported by wildcard into each module or interface that needs them
*/

package tcb_pkg;

  ////////////////////////////////////////
  // bus widths
  ////////////////////////////////////////

  // data bus width in bits
  localparam int DAT_W = 32;

  // one enable per byte lane
  localparam int BEN_W = DAT_W / 8;

  ////////////////////////////////////////
  // load/store access opcodes
  ////////////////////////////////////////

  // loads first, stores last
  // bit 2 alone does not separate loads from stores
  typedef enum logic [2:0] {
    LB  = 3'd0,  // signed byte load
    LH  = 3'd1,  // signed halfword load
    LW  = 3'd2,  // word load
    LBU = 3'd3,  // unsigned byte load
    LHU = 3'd4,  // unsigned halfword load
    SB  = 3'd5,  // byte store
    SH  = 3'd6,  // halfword store
    SW  = 3'd7   // word store
  } ls_op_t;

  ////////////////////////////////////////
  // arbiter state
  ////////////////////////////////////////

  // which manager won the last transfer
  // also serves as route tag for the response
  typedef enum logic {
    FETCH_LAST = 1'b0,
    LS_LAST    = 1'b1
  } arb_state_t;

endpackage

//--- hdl/tcb_if.sv
/*
  valid/ready request bus with byte enables and a fixed one-cycle response
  man modport on the requester side, sub modport on the responder side
*/

`timescale 1ns/1ps

interface tcb_if import tcb_pkg::*; #(
  parameter int ADR_W = 12
) ();

  // request handshake
  logic             vld;
  logic             rdy;

  // request payload, held stable until vld && rdy
  logic             wen;
  logic [ADR_W-1:0] adr;
  logic [BEN_W-1:0] ben;
  logic [DAT_W-1:0] wdt;

  // response, exactly one cycle after the transfer
  logic [DAT_W-1:0] rdt;
  logic             rsp_vld;

  // requester view
  modport man (
    output vld,
    output wen,
    output adr,
    output ben,
    output wdt,
    input  rdy,
    input  rdt,
    input  rsp_vld
  );

  // responder view
  modport sub (
    input  vld,
    input  wen,
    input  adr,
    input  ben,
    input  wdt,
    output rdy,
    output rdt,
    output rsp_vld
  );

endinterface

//--- hdl/tcb_fetch_port.sv
/*
  instruction fetch requester, word reads only
  turns plain fetch ports into bus requests and flags unaligned fetches
*/

`timescale 1ns/1ps

module tcb_fetch_port import tcb_pkg::*; #(
  parameter int ADR_W = 12
) (
  input  logic             bus_if,
  input  logic             rst_n,
  // fetch request
  input  logic             vld,
  input  logic [ADR_W-1:0] adr,
  output logic             rdy,
  // fetch response
  output logic             rsp_vld,
  output logic             rsp_err,
  output logic [DAT_W-1:0] rdt,
  // towards the arbiter
  tcb_if.man               bus
);

  // byte offset bits inside a word
  localparam int OFF_W = $clog2(DAT_W / 8);

  logic err_q;

  ////////////////////////////////////////
  // request side
  ////////////////////////////////////////

  // always a full word read at the word boundary
  assign bus.vld = vld;
  assign bus.wen = 1'b0;
  assign bus.adr = {adr[ADR_W-1:OFF_W], {OFF_W{1'b0}}};
  assign bus.ben = '1;
  assign bus.wdt = '0;

  // ready comes straight from the arbiter grant
  assign rdy = bus.rdy;

  ////////////////////////////////////////
  // response side
  ////////////////////////////////////////

  // unaligned flag captured at the handshake
  always_ff @(posedge bus_if) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (vld && bus.rdy) begin
      err_q <= |adr[OFF_W-1:0];
    end
  end

  assign rsp_vld = bus.rsp_vld;
  assign rsp_err = bus.rsp_vld && err_q;
  assign rdt     = bus.rdt;

  // a response only follows a fetch accepted one cycle earlier
  assert property (@(posedge bus_if) disable iff (!rst_n)
    bus.rsp_vld |-> $past(vld && bus.rdy))
    else $error("fetch response without a fetch transfer");

endmodule

//--- hdl/tcb_ls_port.sv
/*
  load/store requester
  builds byte enables from opcode and address, aligns store data onto lanes,
  then shifts and extends the returned word for loads
*/

`timescale 1ns/1ps

module tcb_ls_port import tcb_pkg::*; #(
  parameter int ADR_W = 12
) (
  input  logic             bus_if,
  input  logic             rst_n,
  // load/store request
  input  logic             vld,
  input  ls_op_t           op,
  input  logic [ADR_W-1:0] adr,
  input  logic [DAT_W-1:0] wdt,
  output logic             rdy,
  // load/store response
  output logic             rsp_vld,
  output logic             rsp_err,
  output logic [DAT_W-1:0] rdt,
  // towards the arbiter
  tcb_if.man               bus
);

  localparam int OFF_W = $clog2(BEN_W);

  logic [OFF_W-1:0] off;
  logic [BEN_W-1:0] ben_raw;
  logic             mis;

  // captured at the handshake
  logic             err_q;
  ls_op_t           op_q;
  logic [OFF_W-1:0] off_q;

  logic [DAT_W-1:0] rdt_sh;

  ////////////////////////////////////////
  // request decode
  ////////////////////////////////////////

  assign off = adr[OFF_W-1:0];

  always_comb begin
    ben_raw = '1;
    mis     = 1'b0;
    case (op)
      LB, LBU, SB: begin
        ben_raw = BEN_W'(1) << off;
      end
      LH, LHU, SH: begin
        ben_raw = BEN_W'(3) << off;
        // halfword needs an even address
        mis     = off[0];
      end
      default: begin
        // word accesses sit on a word boundary
        ben_raw = '1;
        mis     = |off;
      end
    endcase
  end

  assign bus.vld = vld;
  assign bus.wen = (op == SB) || (op == SH) || (op == SW);
  assign bus.adr = {adr[ADR_W-1:OFF_W], {OFF_W{1'b0}}};
  // misaligned access touches no lane at all
  assign bus.ben = mis ? '0 : ben_raw;
  assign bus.wdt = wdt << {off, 3'b000};

  assign rdy = bus.rdy;

  ////////////////////////////////////////
  // response formatting
  ////////////////////////////////////////

  always_ff @(posedge bus_if) begin
    if (!rst_n) begin
      err_q <= 1'b0;
    end else if (vld && bus.rdy) begin
      err_q <= mis;
    end
  end

  // opcode and offset only matter in the response cycle
  always_ff @(posedge bus_if) begin
    if (vld && bus.rdy) begin
      op_q  <= op;
      off_q <= off;
    end
  end

  // addressed byte or halfword down to lane 0
  assign rdt_sh = bus.rdt >> {off_q, 3'b000};

  always_comb begin
    case (op_q)
      LB:      rdt = {{(DAT_W-8){rdt_sh[7]}}, rdt_sh[7:0]};
      LH:      rdt = {{(DAT_W-16){rdt_sh[15]}}, rdt_sh[15:0]};
      LW:      rdt = rdt_sh;
      LBU:     rdt = {{(DAT_W-8){1'b0}}, rdt_sh[7:0]};
      LHU:     rdt = {{(DAT_W-16){1'b0}}, rdt_sh[15:0]};
      // stores return no data
      default: rdt = '0;
    endcase
  end

  assign rsp_vld = bus.rsp_vld;
  assign rsp_err = bus.rsp_vld && err_q;

endmodule

//--- hdl/tcb_arbiter.sv
/*
  two-manager round-robin arbiter in front of a single subordinate
  grant is combinational, responses are routed by the last winner
*/

`timescale 1ns/1ps

module tcb_arbiter import tcb_pkg::*; #(
  parameter int ADR_W = 12
) (
  input  logic bus_if,
  input  logic rst_n,
  tcb_if.sub   man_fetch,
  tcb_if.sub   man_ls,
  tcb_if.man   mem
);

  arb_state_t       last_q;
  logic             rsp_vld_q;
  logic             gnt_fetch;
  logic             gnt_ls;
  logic             xfr;
  logic [ADR_W-1:0] adr_mux;

  ////////////////////////////////////////
  // grant
  ////////////////////////////////////////

  // fetch wins if alone, or if ls won last time
  assign gnt_fetch = man_fetch.vld && (!man_ls.vld || (last_q == LS_LAST));
  assign gnt_ls    = man_ls.vld && !gnt_fetch;

  assign man_fetch.rdy = gnt_fetch && mem.rdy;
  assign man_ls.rdy    = gnt_ls && mem.rdy;

  ////////////////////////////////////////
  // request mux
  ////////////////////////////////////////

  assign adr_mux = gnt_ls ? man_ls.adr : man_fetch.adr;

  assign mem.vld = man_fetch.vld || man_ls.vld;
  assign mem.wen = gnt_ls ? man_ls.wen : man_fetch.wen;
  assign mem.adr = adr_mux;
  assign mem.ben = gnt_ls ? man_ls.ben : man_fetch.ben;
  assign mem.wdt = gnt_ls ? man_ls.wdt : man_fetch.wdt;

  assign xfr = mem.vld && mem.rdy;

  ////////////////////////////////////////
  // state and route
  ////////////////////////////////////////

  // last winner doubles as the response route tag
  always_ff @(posedge bus_if) begin
    if (!rst_n) begin
      last_q    <= LS_LAST;
      rsp_vld_q <= 1'b0;
    end else begin
      rsp_vld_q <= xfr;
      if (xfr) begin
        last_q <= gnt_ls ? LS_LAST : FETCH_LAST;
      end
    end
  end

  // response back to whoever was granted one cycle ago
  assign man_fetch.rsp_vld = mem.rsp_vld && (last_q == FETCH_LAST);
  assign man_ls.rsp_vld    = mem.rsp_vld && (last_q == LS_LAST);
  assign man_fetch.rdt     = mem.rdt;
  assign man_ls.rdt        = mem.rdt;

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  // loser of a conflict is granted in the next cycle
  assert property (@(posedge bus_if) disable iff (!rst_n)
    (man_fetch.vld && man_ls.vld && man_fetch.rdy) |=>
      (!man_ls.vld || man_ls.rdy || !mem.rdy))
    else $error("ls lost two conflicts in a row");

  assert property (@(posedge bus_if) disable iff (!rst_n)
    (man_fetch.vld && man_ls.vld && man_ls.rdy) |=>
      (!man_fetch.vld || man_fetch.rdy || !mem.rdy))
    else $error("fetch lost two conflicts in a row");

  // subordinate answers only one cycle after a transfer
  assert property (@(posedge bus_if) disable iff (!rst_n)
    mem.rsp_vld |-> rsp_vld_q)
    else $error("response without a transfer");

endmodule

//--- hdl/tcb_sram.sv
/*
  single-port synchronous byte-lane RAM, always ready
  read data and response valid come one cycle after the transfer
*/

`timescale 1ns/1ps

module tcb_sram import tcb_pkg::*; #(
  parameter int ADR_W = 12
) (
  input  logic bus_if,
  input  logic rst_n,
  tcb_if.sub   bus
);

  localparam int OFF_W = $clog2(BEN_W);
  localparam int SIZE  = 2 ** ADR_W;

  // byte wide storage
  logic [7:0]       mem_q [SIZE];
  logic [DAT_W-1:0] rdt_q;
  logic             rsp_vld_q;
  logic             xfr;

  // never stalls
  assign bus.rdy = 1'b1;
  assign xfr     = bus.vld && bus.rdy;

  ////////////////////////////////////////
  // array access
  ////////////////////////////////////////

  always_ff @(posedge bus_if) begin
    if (xfr) begin
      for (int b = 0; b < BEN_W; b++) begin
        if (bus.wen) begin
          // write each enabled lane
          if (bus.ben[b]) begin
            mem_q[{bus.adr[ADR_W-1:OFF_W], OFF_W'(b)}] <= bus.wdt[8*b +: 8];
          end
        end else begin
          // lanes not enabled read as zero
          if (bus.ben[b]) begin
            rdt_q[8*b +: 8] <= mem_q[{bus.adr[ADR_W-1:OFF_W], OFF_W'(b)}];
          end else begin
            rdt_q[8*b +: 8] <= 8'h00;
          end
        end
      end
    end
  end

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////

  always_ff @(posedge bus_if) begin
    if (!rst_n) begin
      rsp_vld_q <= 1'b0;
    end else begin
      rsp_vld_q <= xfr;
    end
  end

  assign bus.rdt     = rdt_q;
  assign bus.rsp_vld = rsp_vld_q;

  // requesters must present word addresses
  assert property (@(posedge bus_if) disable iff (!rst_n)
    xfr |-> (bus.adr[OFF_W-1:0] == '0))
    else $error("unaligned address reached the RAM");

endmodule

//--- hdl/tcb_mem_top.sv
/*
  shared memory subsystem top level
  fetch and load/store requesters share one RAM through a round-robin arbiter
*/

`timescale 1ns/1ps

module tcb_mem_top import tcb_pkg::*; #(
  parameter int ADR_W = 12
) (
  input  logic             bus_if,
  input  logic             rst_n,

  ////////////////////////////////////////
  // fetch side
  ////////////////////////////////////////
  input  logic             fetch_vld,
  input  logic [ADR_W-1:0] fetch_adr,
  output logic             fetch_rdy,
  output logic             fetch_rsp_vld,
  output logic             fetch_rsp_err,
  output logic [DAT_W-1:0] fetch_rdt,

  ////////////////////////////////////////
  // load/store side
  ////////////////////////////////////////
  input  logic             ls_vld,
  input  ls_op_t           ls_op,
  input  logic [ADR_W-1:0] ls_adr,
  input  logic [DAT_W-1:0] ls_wdt,
  output logic             ls_rdy,
  output logic             ls_rsp_vld,
  output logic             ls_rsp_err,
  output logic [DAT_W-1:0] ls_rdt
);

  // port to arbiter, arbiter to RAM
  tcb_if #(.ADR_W(ADR_W)) if_fetch ();
  tcb_if #(.ADR_W(ADR_W)) if_ls ();
  tcb_if #(.ADR_W(ADR_W)) if_mem ();

  // word reads only
  tcb_fetch_port #(.ADR_W(ADR_W)) i_fetch_port (
    .bus_if  (bus_if),
    .rst_n   (rst_n),
    .vld     (fetch_vld),
    .adr     (fetch_adr),
    .rdy     (fetch_rdy),
    .rsp_vld (fetch_rsp_vld),
    .rsp_err (fetch_rsp_err),
    .rdt     (fetch_rdt),
    .bus     (if_fetch.man)
  );

  // byte, halfword and word loads and stores
  tcb_ls_port #(.ADR_W(ADR_W)) i_ls_port (
    .bus_if  (bus_if),
    .rst_n   (rst_n),
    .vld     (ls_vld),
    .op      (ls_op),
    .adr     (ls_adr),
    .wdt     (ls_wdt),
    .rdy     (ls_rdy),
    .rsp_vld (ls_rsp_vld),
    .rsp_err (ls_rsp_err),
    .rdt     (ls_rdt),
    .bus     (if_ls.man)
  );

  tcb_arbiter #(.ADR_W(ADR_W)) i_arbiter (
    .bus_if    (bus_if),
    .rst_n     (rst_n),
    .man_fetch (if_fetch.sub),
    .man_ls    (if_ls.sub),
    .mem       (if_mem.man)
  );

  tcb_sram #(.ADR_W(ADR_W)) i_sram (
    .bus_if (bus_if),
    .rst_n  (rst_n),
    .bus    (if_mem.sub)
  );

endmodule

//--- test/tcb_mem_tb.sv
/*
  testbench for the shared memory subsystem
  random fetch and load/store traffic from a fixed seed, checked against a
  byte-array model with a one-deep expected slot per port
*/

`timescale 1ns/1ps

module tcb_mem_tb import tcb_pkg::*; ();

  localparam int ADR_W   = 8;
  localparam int SIZE    = 1 << ADR_W;
  localparam int WORDS   = SIZE / BEN_W;
  localparam int N_REQ   = 2000;
  // one transfer per cycle at best, half again for conflicts and idle draws
  localparam int MAX_CYC = N_REQ + N_REQ / 2;
  localparam int unsigned SEED = 32'h783a72fe;

  logic             bus_if;
  logic             rst_n;
  logic             fetch_vld;
  logic [ADR_W-1:0] fetch_adr;
  logic             fetch_rdy;
  logic             fetch_rsp_vld;
  logic             fetch_rsp_err;
  logic [DAT_W-1:0] fetch_rdt;
  logic             ls_vld;
  ls_op_t           ls_op;
  logic [ADR_W-1:0] ls_adr;
  logic [DAT_W-1:0] ls_wdt;
  logic             ls_rdy;
  logic             ls_rsp_vld;
  logic             ls_rsp_err;
  logic [DAT_W-1:0] ls_rdt;

  // reference memory
  logic [7:0]       model [SIZE];
  arb_state_t       last_win;

  // expected response slots
  logic             exp_f_vld;
  logic             exp_f_err;
  logic [DAT_W-1:0] exp_f_rdt;
  logic             exp_l_vld;
  logic             exp_l_err;
  logic             exp_l_chk;
  logic [DAT_W-1:0] exp_l_rdt;

  logic             f_pend;
  logic             l_pend;
  int               f_wait;
  int               l_wait;
  int               issued;
  int               init_idx;
  int               init_acc;
  int               cycles;
  int               checks;
  int               errors;
  logic             finished;
  int unsigned      seed_ret;

  tcb_mem_top #(.ADR_W(ADR_W)) i_tcb_mem_top (
    .bus_if        (bus_if),
    .rst_n         (rst_n),
    .fetch_vld     (fetch_vld),
    .fetch_adr     (fetch_adr),
    .fetch_rdy     (fetch_rdy),
    .fetch_rsp_vld (fetch_rsp_vld),
    .fetch_rsp_err (fetch_rsp_err),
    .fetch_rdt     (fetch_rdt),
    .ls_vld        (ls_vld),
    .ls_op         (ls_op),
    .ls_adr        (ls_adr),
    .ls_wdt        (ls_wdt),
    .ls_rdy        (ls_rdy),
    .ls_rsp_vld    (ls_rsp_vld),
    .ls_rsp_err    (ls_rsp_err),
    .ls_rdt        (ls_rdt)
  );

  initial begin
    bus_if = 1'b0;
    forever #50 bus_if = ~bus_if;
  end

  ////////////////////////////////////////
  // model rules
  ////////////////////////////////////////

  // little endian word around a byte address
  function automatic logic [DAT_W-1:0] word_at(logic [ADR_W-1:0] a);
    logic [ADR_W-1:0] base;
    logic [DAT_W-1:0] w;
    base = {a[ADR_W-1:2], 2'b00};
    for (int b = 0; b < BEN_W; b++) begin
      w[8*b +: 8] = model[ADR_W'(base + b)];
    end
    return w;
  endfunction

  function automatic logic misaligned(ls_op_t op, logic [ADR_W-1:0] a);
    case (op)
      LH, LHU, SH: return a[0];
      LW, SW:      return |a[1:0];
      default:     return 1'b0;
    endcase
  endfunction

  function automatic logic is_store(ls_op_t op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

  // byte or halfword picked straight from the model, then extended
  function automatic logic [DAT_W-1:0] load_value(ls_op_t op, logic [ADR_W-1:0] a);
    logic [7:0]  lo;
    logic [15:0] half;
    lo   = model[a];
    half = {model[ADR_W'(a + 1)], lo};
    case (op)
      LB:      return {{(DAT_W-8){lo[7]}}, lo};
      LBU:     return {{(DAT_W-8){1'b0}}, lo};
      LH:      return {{(DAT_W-16){half[15]}}, half};
      LHU:     return {{(DAT_W-16){1'b0}}, half};
      default: return word_at(a);
    endcase
  endfunction

  task automatic apply_store(ls_op_t op, logic [ADR_W-1:0] a, logic [DAT_W-1:0] d);
    case (op)
      SB: begin
        model[a] = d[7:0];
      end
      SH: begin
        model[a]               = d[7:0];
        model[ADR_W'(a + 1)]   = d[15:8];
      end
      SW: begin
        for (int b = 0; b < BEN_W; b++) begin
          model[ADR_W'(a + b)] = d[8*b +: 8];
        end
      end
      default: ;
    endcase
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  task automatic draw_fetch();
    fetch_vld = 1'b0;
    // no fetch until every word holds known data
    if (init_acc == WORDS && issued < N_REQ && ($urandom % 4) != 0) begin
      fetch_vld = 1'b1;
      fetch_adr = ADR_W'($urandom);
      // mostly aligned fetches
      if (($urandom % 8) != 0) begin
        fetch_adr[1:0] = 2'b00;
      end
      f_pend = 1'b1;
      issued++;
    end
  endtask

  task automatic draw_ls();
    ls_vld = 1'b0;
    if (init_idx < WORDS) begin
      // fill pass, one word store per word
      ls_vld = 1'b1;
      ls_op  = SW;
      ls_adr = ADR_W'(init_idx * BEN_W);
      ls_wdt = $urandom;
      init_idx++;
      l_pend = 1'b1;
      issued++;
    end else if (init_acc == WORDS && issued < N_REQ && ($urandom % 4) != 0) begin
      ls_vld = 1'b1;
      ls_op  = ls_op_t'(3'($urandom % 8));
      ls_adr = ADR_W'($urandom);
      ls_wdt = $urandom;
      // natural alignment most of the time
      if (($urandom % 4) != 0) begin
        case (ls_op)
          LH, LHU, SH: ls_adr[0] = 1'b0;
          LW, SW:      ls_adr[1:0] = 2'b00;
          default:     ;
        endcase
      end
      l_pend = 1'b1;
      issued++;
    end
  endtask

  ////////////////////////////////////////
  // handshake and response checks
  ////////////////////////////////////////

  task automatic sample_handshakes();
    logic f_gnt;
    logic l_gnt;
    // round robin, fetch wins a conflict after an ls win
    f_gnt = fetch_vld && (!ls_vld || last_win == LS_LAST);
    l_gnt = ls_vld && !f_gnt;
    checks++;
    if (fetch_rdy !== f_gnt) begin
      errors++;
      $display("ERR %0t: fetch_rdy is %b, expected %b", $time, fetch_rdy, f_gnt);
    end
    if (ls_rdy !== l_gnt) begin
      errors++;
      $display("ERR %0t: ls_rdy is %b, expected %b", $time, ls_rdy, l_gnt);
    end
    // cycles spent with vld high and no rdy
    f_wait = (fetch_vld && fetch_rdy !== 1'b1) ? f_wait + 1 : 0;
    l_wait = (ls_vld && ls_rdy !== 1'b1) ? l_wait + 1 : 0;
    if (f_wait > 1 || l_wait > 1) begin
      errors++;
      $display("ERR %0t: waited %0d/%0d cycles for rdy", $time, f_wait, l_wait);
    end
    if (fetch_vld && fetch_rdy === 1'b1) begin
      f_pend    = 1'b0;
      last_win  = FETCH_LAST;
      exp_f_vld = 1'b1;
      exp_f_err = |fetch_adr[1:0];
      exp_f_rdt = word_at(fetch_adr);
    end
    if (ls_vld && ls_rdy === 1'b1) begin
      l_pend    = 1'b0;
      last_win  = LS_LAST;
      if (init_acc < WORDS) begin
        init_acc++;
      end
      exp_l_vld = 1'b1;
      exp_l_err = misaligned(ls_op, ls_adr);
      exp_l_chk = !exp_l_err && !is_store(ls_op);
      exp_l_rdt = load_value(ls_op, ls_adr);
      // misaligned stores never reach memory
      if (!exp_l_err) begin
        apply_store(ls_op, ls_adr, ls_wdt);
      end
    end
  endtask

  task automatic check_responses();
    if (fetch_rsp_vld === 1'b1 && !exp_f_vld) begin
      errors++;
      $display("unexpected fetch response at time %0t", $time);
    end else if (fetch_rsp_vld !== 1'b1 && exp_f_vld) begin
      errors++;
      $display("fetch response missing at time %0t", $time);
    end else if (exp_f_vld) begin
      checks++;
      if (fetch_rsp_err !== exp_f_err || fetch_rdt !== exp_f_rdt) begin
        errors++;
        $display("ERR %0t: fetch got err %b data %h, expected err %b data %h",
                 $time, fetch_rsp_err, fetch_rdt, exp_f_err, exp_f_rdt);
      end
    end
    if (ls_rsp_vld === 1'b1 && !exp_l_vld) begin
      errors++;
      $display("unexpected load/store response at time %0t", $time);
    end else if (ls_rsp_vld !== 1'b1 && exp_l_vld) begin
      errors++;
      $display("load/store response missing at time %0t", $time);
    end else if (exp_l_vld) begin
      checks++;
      if (ls_rsp_err !== exp_l_err || (exp_l_chk && ls_rdt !== exp_l_rdt)) begin
        errors++;
        $display("ERR %0t: ls got err %b data %h, expected err %b data %h",
                 $time, ls_rsp_err, ls_rdt, exp_l_err, exp_l_rdt);
      end
    end
    // slots are one deep
    exp_f_vld = 1'b0;
    exp_l_vld = 1'b0;
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    seed_ret  = $urandom(SEED);
    rst_n     = 1'b0;
    fetch_vld = 1'b0;
    fetch_adr = '0;
    ls_vld    = 1'b0;
    ls_op     = LB;
    ls_adr    = '0;
    ls_wdt    = '0;
    last_win  = LS_LAST;
    exp_f_vld = 1'b0;
    exp_l_vld = 1'b0;
    f_pend    = 1'b0;
    l_pend    = 1'b0;
    f_wait    = 0;
    l_wait    = 0;
    issued    = 0;
    init_idx  = 0;
    init_acc  = 0;
    cycles    = 0;
    checks    = 0;
    errors    = 0;
    finished  = 1'b0;
    repeat (2) @(negedge bus_if);
    rst_n = 1'b1;
    while (!finished && cycles < MAX_CYC) begin
      @(negedge bus_if);
      cycles++;
      // responses to the transfer at the last rising edge
      check_responses();
      if (issued == N_REQ && !f_pend && !l_pend && !exp_f_vld && !exp_l_vld) begin
        finished = 1'b1;
      end else begin
        if (!f_pend) begin
          draw_fetch();
        end
        if (!l_pend) begin
          draw_ls();
        end
        // rdy settles well before the next rising edge
        #10;
        sample_handshakes();
      end
    end
    if (!finished) begin
      $display("timeout: run stopped after %0d cycles with requests still open", cycles);
    end
    $display("cycles: %0d  checks: %0d  errors: %0d", cycles, checks, errors);
    if (finished && errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- tcb_mem.f
hdl/tcb_pkg.sv
hdl/tcb_if.sv
hdl/tcb_fetch_port.sv
hdl/tcb_ls_port.sv
hdl/tcb_arbiter.sv
hdl/tcb_sram.sv
hdl/tcb_mem_top.sv
test/tcb_mem_tb.sv
